// ==== src.f ====
+incdir+source
source/rterm_pkg.sv
source/rterm_apb_regs.sv
source/rterm_calib.sv
source/rterm_code_dist.sv
source/rterm_calib_top.sv
dv/rterm_comp_model.sv
dv/rterm_calib_tb.sv

// ==== dv/rterm_calib_tb.sv ====
// termination calibration testbench
`default_nettype none
`include "rterm_defs.svh"

module rterm_calib_tb;
   import rterm_pkg::*;

   localparam int NB         = `RTERM_NUM_BANKS;
   // one c2c + lvds pass, with some margin for the state hops
   localparam int CAL_CYCLES = `RTERM_WAIT_C2C + `RTERM_WAIT_LVDS + 8 * (`RTERM_SETTLE + 1) + 4;
   localparam int NUM_TESTS  = 6;
   localparam int WATCHDOG   = 20 * NUM_TESTS * CAL_CYCLES * 10;
   localparam int MAX_POLLS  = 2 * CAL_CYCLES;   // three cycles per read, about 6 passes

   logic                     clk_ref;
   logic                     reset_n;
   logic                     psel;
   logic                     penable;
   logic                     pwrite;
   logic [`RTERM_APB_AW-1:0] paddr;
   logic [31:0]              pwdata;
   logic [31:0]              prdata;
   logic                     pready;
   logic                     pslverr;
   logic [2*NB-1:0]          comp_result;
   therm_code_t [NB-1:0]     d_iosg;
   trim_code_t [NB-1:0]      d_lvds;
   logic [2*NB-1:0]          mode;
   therm_code_t [NB-1:0]     c2c_cal_t;    // io cell codes
   trim_code_t [NB-1:0]      lvds_cal;
   trim_code_t               c2c_target [NB];
   trim_code_t               lvds_target [NB];
   int                       err_cnt;

   initial begin
      clk_ref = 1'b0;
      forever #5 clk_ref = ~clk_ref;
   end

   rterm_calib_top dut (
      .clk_ref_i         (clk_ref),
      .reset_n_i         (reset_n),
      .psel_i            (psel),
      .penable_i         (penable),
      .pwrite_i          (pwrite),
      .paddr_i           (paddr),
      .pwdata_i          (pwdata),
      .prdata_o          (prdata),
      .pready_o          (pready),
      .pslverr_o         (pslverr),
      .rtermcal_result_i (comp_result),
      .rtermcal_d_iosg_o (d_iosg),
      .rtermcal_d_lvds_o (d_lvds),
      .rtermcal_mode_o   (mode),
      .calib_c2c_cal_t_o (c2c_cal_t),
      .calib_lvds_cal_o  (lvds_cal)
   );

   for (genvar b = 0; b < NB; b++) begin : g_comp
      rterm_comp_model u_comp (
         .mode_i        (mode[2*b +: 2]),
         .d_iosg_i      (d_iosg[b]),
         .d_lvds_i      (d_lvds[b]),
         .c2c_target_i  (c2c_target[b]),
         .lvds_target_i (lvds_target[b]),
         .result_o      (comp_result[2*b +: 2])
      );
   end

   // ----------------------------------------------------------
   // helpers
   // ----------------------------------------------------------
   function automatic logic [14:0] therm_of(input int n);
      logic [15:0] ones;
      ones = (16'h1 << n) - 16'h1;   // low n bits set
      return ones[14:0];
   endfunction

   function automatic logic [`RTERM_APB_AW-1:0] bank_ovr_addr(input int b);
      return `RTERM_APB_AW'(`RTERM_ADDR_BANK_BASE + b * `RTERM_BANK_STRIDE);
   endfunction

   function automatic logic [`RTERM_APB_AW-1:0] bank_res_addr(input int b);
      return bank_ovr_addr(b) + `RTERM_APB_AW'(4);
   endfunction

   task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic apb_write(input logic [`RTERM_APB_AW-1:0] addr, input logic [31:0] data);
      @(negedge clk_ref);
      psel    = 1'b1;              // setup phase
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk_ref);
      penable = 1'b1;              // access phase, pready always high
      @(negedge clk_ref);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [`RTERM_APB_AW-1:0] addr, output logic [31:0] data);
      @(negedge clk_ref);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge clk_ref);
      penable = 1'b1;
      data    = prdata;            // settled since the last rising edge
      @(negedge clk_ref);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // wait for a bank's done flag to reach level
   task automatic poll_done(input int b, input logic level);
      logic [31:0] d;
      for (int i = 0; i < MAX_POLLS; i++) begin
         apb_read(`RTERM_ADDR_STATUS, d);
         if (d[b] == level) return;
      end
      $display("bank %0d: done flag did not go to %0b in time", b, level);
      err_cnt++;
   endtask

   // poll result reg until it shows the expected codes
   task automatic poll_result(input int b, input logic [31:0] exp);
      logic [31:0] d;
      for (int i = 0; i < MAX_POLLS; i++) begin
         apb_read(bank_res_addr(b), d);
         if (d == exp) return;
      end
      $display("bank %0d: result stuck at %0h instead of %0h", b, d, exp);
      err_cnt++;
   endtask

   task automatic stop_all();
      apb_write(`RTERM_ADDR_CTRL, 32'h0);
      for (int b = 0; b < NB; b++) poll_done(b, 1'b0);
   endtask

   // result reg, io outputs and read-back for the current targets
   task automatic check_bank(input int b);
      logic [31:0] d;
      apb_read(bank_res_addr(b), d);
      check_val($sformatf("bank %0d result", b), d, {24'h0, lvds_target[b], c2c_target[b]});
      check_val($sformatf("bank %0d c2c therm", b), c2c_cal_t[b], therm_of(c2c_target[b]));
      check_val($sformatf("bank %0d lvds code", b), lvds_cal[b], lvds_target[b]);
   endtask

   // ----------------------------------------------------------
   // tests
   // ----------------------------------------------------------
   task automatic test_reset();
      logic [31:0] d;
      apb_read(`RTERM_ADDR_CTRL, d);
      check_val("ctrl", d, 32'h0);
      apb_read(`RTERM_ADDR_STATUS, d);
      check_val("status", d, 32'h0);
      apb_read(bank_ovr_addr(NB), d);   // first address past the banks
      check_val("unmapped read", d, 32'h0);
      for (int b = 0; b < NB; b++) begin
         apb_read(bank_ovr_addr(b), d);
         check_val($sformatf("bank %0d override", b), d, 32'h0);
         apb_read(bank_res_addr(b), d);
         check_val($sformatf("bank %0d result", b), d, 32'h88);   // mid scale
         check_val($sformatf("bank %0d c2c therm", b), c2c_cal_t[b], 32'h00ff);
         check_val($sformatf("bank %0d lvds code", b), lvds_cal[b], 32'h8);
         check_val($sformatf("bank %0d macro c2c code", b), d_iosg[b], 32'h00ff);
         check_val($sformatf("bank %0d macro lvds code", b), d_lvds[b], 32'h8);
      end
      check_val("mode", mode, 32'h0);
      check_val("pready", pready, 32'h1);
      check_val("pslverr", pslverr, 32'h0);
   endtask

   task automatic test_single_bank();
      logic [31:0] d;
      c2c_target[0]  = 4'd5;
      lvds_target[0] = 4'd11;
      apb_write(`RTERM_ADDR_CTRL, 32'h1);
      poll_done(0, 1'b1);
      check_bank(0);
      apb_read(`RTERM_ADDR_STATUS, d);
      check_val("bank 1 done", d[1], 32'h0);
      apb_read(bank_res_addr(1), d);
      check_val("bank 1 result", d, 32'h88);        // idle bank untouched
      check_val("bank 1 c2c therm", c2c_cal_t[1], 32'h00ff);
      check_val("bank 1 lvds code", lvds_cal[1], 32'h8);
      check_val("bank 1 macro c2c code", d_iosg[1], 32'h00ff);
      check_val("bank 1 macro lvds code", d_lvds[1], 32'h8);
      check_val("bank 1 mode", mode[3:2], 32'h0);
      stop_all();
   endtask

   task automatic test_both_banks();
      for (int b = 0; b < NB; b++) begin
         c2c_target[b]  = trim_code_t'($urandom_range(15, 0));
         lvds_target[b] = trim_code_t'($urandom_range(15, 0));
      end
      apb_write(`RTERM_ADDR_CTRL, (32'h1 << NB) - 32'h1);
      for (int b = 0; b < NB; b++) poll_done(b, 1'b1);
      for (int b = 0; b < NB; b++) check_bank(b);
      stop_all();
   endtask

   task automatic test_override();
      trim_code_t  ov_c;
      trim_code_t  ov_l;
      logic [31:0] ovr;
      logic [31:0] d;
      ov_c = ~c2c_target[0];    // always differs from calibrated code
      ov_l = ~lvds_target[0];
      ovr  = {22'h0, ov_l, 1'b1, ov_c, 1'b1};
      apb_write(bank_ovr_addr(0), ovr);
      apb_read(bank_ovr_addr(0), d);
      check_val("bank 0 override reg", d, ovr);
      check_val("overridden c2c therm", c2c_cal_t[0], therm_of(ov_c));
      check_val("overridden lvds code", lvds_cal[0], ov_l);
      apb_read(bank_res_addr(0), d);
      check_val("result with override", d, {24'h0, ov_l, c2c_target[0]});
      check_val("bank 1 c2c therm", c2c_cal_t[1], therm_of(c2c_target[1]));
      apb_write(bank_ovr_addr(0), 32'h0);
      check_bank(0);
   endtask

   task automatic test_tracking();
      logic [31:0] d;
      c2c_target[0]  = 4'd3;
      lvds_target[0] = 4'd12;
      apb_write(`RTERM_ADDR_CTRL, 32'h1);
      poll_done(0, 1'b1);
      check_bank(0);
      // move both targets while the bank keeps running
      c2c_target[0]  = c2c_target[0] + trim_code_t'($urandom_range(14, 0) + 1);
      lvds_target[0] = lvds_target[0] + trim_code_t'($urandom_range(14, 0) + 1);
      poll_result(0, {24'h0, lvds_target[0], c2c_target[0]});
      apb_read(`RTERM_ADDR_STATUS, d);
      check_val("bank 0 done while tracking", d[0], 32'h1);
      check_bank(0);
   endtask

   task automatic test_disable();
      logic [31:0] d;
      apb_write(`RTERM_ADDR_CTRL, 32'h0);
      poll_done(0, 1'b0);
      check_val("mode after disable", mode, 32'h0);
      // idle engine drives its stored codes to the macro
      check_val("macro c2c code after disable", d_iosg[0], therm_of(c2c_target[0]));
      check_val("macro lvds code after disable", d_lvds[0], lvds_target[0]);
      apb_read(`RTERM_ADDR_CTRL, d);
      check_val("ctrl", d, 32'h0);
      check_bank(0);            // last codes kept
   endtask

   // ----------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------
   initial begin
      reset_n = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      err_cnt = 0;
      for (int b = 0; b < NB; b++) begin
         c2c_target[b]  = 4'd8;
         lvds_target[b] = 4'd8;
      end
      void'($urandom(32'hd5303926));
      repeat (4) @(negedge clk_ref);
      reset_n = 1'b1;

      test_reset();
      test_single_bank();
      test_both_banks();
      test_override();
      test_tracking();
      test_disable();

      $display("tests finished with %0d error(s)", err_cnt);
      if (err_cnt == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   // watchdog, far beyond the expected run length
   initial begin
      #(WATCHDOG);
      $display("watchdog expired before the tests finished");
      $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== dv/rterm_comp_model.sv ====
// termination comparator macro model
`default_nettype none

module rterm_comp_model (
   input  logic [1:0]             mode_i,         // [0] c2c trim, [1] lvds trim
   input  rterm_pkg::therm_code_t d_iosg_i,       // c2c trial, thermometer
   input  rterm_pkg::trim_code_t  d_lvds_i,       // lvds trial, binary
   input  rterm_pkg::trim_code_t  c2c_target_i,   // code where the c2c leg matches
   input  rterm_pkg::trim_code_t  lvds_target_i,  // code where the lvds leg matches
   output logic [1:0]             result_o        // high while trial above target
);
   import rterm_pkg::*;

   int unsigned c2c_level;   // number of c2c legs switched on

   // ----------------------------------------------------------
   // thermometer trial back to a leg count
   // ----------------------------------------------------------
   always_comb begin
      c2c_level = 0;
      for (int i = 1; i <= 15; i++) begin
         c2c_level += d_iosg_i[i];
      end
   end

   // ----------------------------------------------------------
   // comparator outputs, quiet unless the leg is being trimmed
   // ----------------------------------------------------------
   assign result_o[0] = mode_i[0] && (c2c_level > c2c_target_i);
   assign result_o[1] = mode_i[1] && (d_lvds_i > lvds_target_i);

endmodule

`default_nettype wire

// ==== source/rterm_calib_top.sv ====
// termination calibration top level
`default_nettype none
`include "rterm_defs.svh"

module rterm_calib_top (
   input  logic                                         clk_ref_i,
   input  logic                                         reset_n_i,
   // apb
   input  logic                                         psel_i,
   input  logic                                         penable_i,
   input  logic                                         pwrite_i,
   input  logic [`RTERM_APB_AW-1:0]                     paddr_i,
   input  logic [31:0]                                  pwdata_i,
   output logic [31:0]                                  prdata_o,
   output logic                                         pready_o,
   output logic                                         pslverr_o,
   // comparator macros, two bits per bank
   input  logic [2*`RTERM_NUM_BANKS-1:0]                rtermcal_result_i,
   output rterm_pkg::therm_code_t [`RTERM_NUM_BANKS-1:0] rtermcal_d_iosg_o,
   output rterm_pkg::trim_code_t [`RTERM_NUM_BANKS-1:0]  rtermcal_d_lvds_o,
   output logic [2*`RTERM_NUM_BANKS-1:0]                rtermcal_mode_o,
   // io cells
   output rterm_pkg::therm_code_t [`RTERM_NUM_BANKS-1:0] calib_c2c_cal_t_o,
   output rterm_pkg::trim_code_t [`RTERM_NUM_BANKS-1:0]  calib_lvds_cal_o
);
   import rterm_pkg::*;

   localparam int NB = `RTERM_NUM_BANKS;

   logic [NB-1:0]       calib_en;
   logic [NB-1:0]       calib_done;
   logic [NB-1:0]       c2c_ovr;
   logic [NB-1:0]       lvds_ovr;
   trim_code_t [NB-1:0] c2c_val;
   trim_code_t [NB-1:0] lvds_val;
   trim_code_t [NB-1:0] cal_c2c;    // engine results
   trim_code_t [NB-1:0] cal_lvds;
   trim_code_t [NB-1:0] rb_c2c;     // read-back codes
   trim_code_t [NB-1:0] rb_lvds;

   // ----------------------------------------------------------
   // register block
   // ----------------------------------------------------------
   rterm_apb_regs u_regs (
      .clk_ref_i    (clk_ref_i),
      .reset_n_i    (reset_n_i),
      .psel_i       (psel_i),
      .penable_i    (penable_i),
      .pwrite_i     (pwrite_i),
      .paddr_i      (paddr_i),
      .pwdata_i     (pwdata_i),
      .prdata_o     (prdata_o),
      .pready_o     (pready_o),
      .pslverr_o    (pslverr_o),
      .calib_en_o   (calib_en),
      .calib_done_i (calib_done),
      .c2c_ovr_o    (c2c_ovr),
      .c2c_val_o    (c2c_val),
      .lvds_ovr_o   (lvds_ovr),
      .lvds_val_o   (lvds_val),
      .rb_c2c_i     (rb_c2c),
      .rb_lvds_i    (rb_lvds)
   );

   // ----------------------------------------------------------
   // one engine per bank
   // ----------------------------------------------------------
   for (genvar b = 0; b < NB; b++) begin : g_bank
      rterm_calib u_calib (
         .clk_ref_i         (clk_ref_i),
         .reset_n_i         (reset_n_i),
         .calib_en_i        (calib_en[b]),
         .calib_done_o      (calib_done[b]),
         .cal_c2c_o         (cal_c2c[b]),
         .cal_lvds_o        (cal_lvds[b]),
         .rtermcal_result_i (rtermcal_result_i[2*b +: 2]),
         .rtermcal_d_iosg_o (rtermcal_d_iosg_o[b]),
         .rtermcal_d_lvds_o (rtermcal_d_lvds_o[b]),
         .rtermcal_mode_o   (rtermcal_mode_o[2*b +: 2])
      );
   end

   // ----------------------------------------------------------
   // override, encoding and read-back
   // ----------------------------------------------------------
   rterm_code_dist u_dist (
      .c2c_ovr_i         (c2c_ovr),
      .c2c_val_i         (c2c_val),
      .lvds_ovr_i        (lvds_ovr),
      .lvds_val_i        (lvds_val),
      .cal_c2c_i         (cal_c2c),
      .cal_lvds_i        (cal_lvds),
      .calib_c2c_cal_t_o (calib_c2c_cal_t_o),
      .calib_lvds_cal_o  (calib_lvds_cal_o),
      .rb_c2c_o          (rb_c2c),
      .rb_lvds_o         (rb_lvds)
   );

endmodule

`default_nettype wire

// ==== source/rterm_code_dist.sv ====
// termination code distribution
`default_nettype none
`include "rterm_defs.svh"

module rterm_code_dist (
   // overrides from register block
   input  logic [`RTERM_NUM_BANKS-1:0]                 c2c_ovr_i,
   input  rterm_pkg::trim_code_t [`RTERM_NUM_BANKS-1:0]  c2c_val_i,
   input  logic [`RTERM_NUM_BANKS-1:0]                 lvds_ovr_i,
   input  rterm_pkg::trim_code_t [`RTERM_NUM_BANKS-1:0]  lvds_val_i,
   // calibrated codes from the engines
   input  rterm_pkg::trim_code_t [`RTERM_NUM_BANKS-1:0]  cal_c2c_i,
   input  rterm_pkg::trim_code_t [`RTERM_NUM_BANKS-1:0]  cal_lvds_i,
   // io cells
   output rterm_pkg::therm_code_t [`RTERM_NUM_BANKS-1:0] calib_c2c_cal_t_o,
   output rterm_pkg::trim_code_t [`RTERM_NUM_BANKS-1:0]  calib_lvds_cal_o,
   // read-back to register block
   output rterm_pkg::trim_code_t [`RTERM_NUM_BANKS-1:0]  rb_c2c_o,
   output rterm_pkg::trim_code_t [`RTERM_NUM_BANKS-1:0]  rb_lvds_o
);
   import rterm_pkg::*;

   localparam int NB = `RTERM_NUM_BANKS;

   trim_code_t [NB-1:0] c2c_sel;    // code applied to c2c cells
   trim_code_t [NB-1:0] lvds_sel;   // code applied to lvds cells

   // ----------------------------------------------------------
   // per bank override mux and encoding
   // ----------------------------------------------------------
   always_comb begin
      for (int b = 0; b < NB; b++) begin
         c2c_sel[b]  = c2c_ovr_i[b]  ? c2c_val_i[b]  : cal_c2c_i[b];
         lvds_sel[b] = lvds_ovr_i[b] ? lvds_val_i[b] : cal_lvds_i[b];

         calib_c2c_cal_t_o[b] = therm_encode(c2c_sel[b]);
         calib_lvds_cal_o[b]  = lvds_sel[b];   // lvds cells take binary

         // c2c read-back bypasses the override, lvds does not
         rb_c2c_o[b]  = cal_c2c_i[b];
         rb_lvds_o[b] = lvds_sel[b];
      end
   end

endmodule

`default_nettype wire

// ==== source/rterm_calib.sv ====
// termination sar calibration engine
`default_nettype none
`include "rterm_defs.svh"

module rterm_calib (
   input  logic                   clk_ref_i,
   input  logic                   reset_n_i,
   // register block
   input  logic                   calib_en_i,      // continuous tracking while high
   output logic                   calib_done_o,
   // result codes, override applied downstream
   output rterm_pkg::trim_code_t  cal_c2c_o,
   output rterm_pkg::trim_code_t  cal_lvds_o,
   // comparator macro, asynchronous
   input  logic [1:0]             rtermcal_result_i,  // high means trial code too big
   output rterm_pkg::therm_code_t rtermcal_d_iosg_o,
   output rterm_pkg::trim_code_t  rtermcal_d_lvds_o,
   output logic [1:0]             rtermcal_mode_o     // [0] c2c trim, [1] lvds trim
);
   import rterm_pkg::*;

   localparam int CNT_W = 8;

   cal_state_t       state_r;
   cal_state_t       state_nxt;
   logic             lvds_r;       // 0 c2c search, 1 lvds search
   logic             lvds_nxt;
   trim_code_t       shift_r;      // bit under test
   trim_code_t       shift_nxt;
   trim_code_t       val_r;        // sar trial code
   trim_code_t       val_nxt;
   logic [CNT_W-1:0] cnt_r;        // wait / settle down-counter
   logic             cnt_set;
   logic             sar_done;     // last bit decided this cycle
   logic [1:0]       sync1_r;
   logic [1:0]       sync2_r;
   logic             cmp_keep;     // keep current trial bit
   trim_code_t       cal_c2c_r;
   trim_code_t       cal_lvds_r;
   logic             done_r;
   logic             searching;

   // ----------------------------------------------------------
   // comparator synchronizer, two flops per bit
   // ----------------------------------------------------------
   always_ff @(posedge clk_ref_i or negedge reset_n_i) begin
      if (!reset_n_i) begin
         sync1_r <= 2'b00;
         sync2_r <= 2'b00;
      end else begin
         sync1_r <= rtermcal_result_i;
         sync2_r <= sync1_r;
      end
   end

   // select comparator of the running search, low keeps the bit
   assign cmp_keep = lvds_r ? ~sync2_r[1] : ~sync2_r[0];

   // ----------------------------------------------------------
   // fsm and sar registers
   // ----------------------------------------------------------
   always_ff @(posedge clk_ref_i or negedge reset_n_i) begin
      if (!reset_n_i) begin
         state_r <= CAL_IDLE;
         lvds_r  <= 1'b0;
         shift_r <= '0;
         val_r   <= '0;
      end else begin
         state_r <= state_nxt;
         lvds_r  <= lvds_nxt;
         shift_r <= shift_nxt;
         val_r   <= val_nxt;
      end
   end

   always_comb begin
      state_nxt = state_r;
      lvds_nxt  = lvds_r;
      shift_nxt = shift_r;
      val_nxt   = val_r;
      cnt_set   = 1'b0;
      sar_done  = 1'b0;
      case (state_r)
         CAL_IDLE: begin
            if (calib_en_i) begin
               state_nxt = CAL_WAIT;
               cnt_set   = 1'b1;
               lvds_nxt  = 1'b0;        // always start with c2c
               val_nxt   = 4'b1000;
            end
         end
         CAL_WAIT: begin
            shift_nxt = 4'b1000;        // msb first
            val_nxt   = 4'b1000;
            if (cnt_r == '0) begin
               state_nxt = CAL_SAR;
               cnt_set   = 1'b1;
            end
         end
         CAL_SAR: begin
            if (cnt_r == '0) begin      // settled, decide one bit
               if (shift_r == 4'b0001) begin
                  sar_done = 1'b1;
                  lvds_nxt = ~lvds_r;
                  // an lvds search always follows c2c
                  if (calib_en_i || !lvds_r) begin
                     state_nxt = CAL_WAIT;
                     cnt_set   = 1'b1;
                     val_nxt   = 4'b1000;
                  end else begin
                     state_nxt = CAL_IDLE;
                  end
               end else begin
                  cnt_set   = 1'b1;
                  shift_nxt = {1'b0, shift_r[3:1]};
                  val_nxt   = (val_r & (~shift_r | {4{cmp_keep}})) | shift_nxt;
               end
            end
         end
         default: state_nxt = CAL_IDLE;
      endcase
   end

   // ----------------------------------------------------------
   // wait / settle timer
   // ----------------------------------------------------------
   always_ff @(posedge clk_ref_i or negedge reset_n_i) begin
      if (!reset_n_i) begin
         cnt_r <= '0;
      end else if (cnt_set) begin
         if (state_nxt == CAL_WAIT) begin
            cnt_r <= lvds_nxt ? CNT_W'(`RTERM_WAIT_LVDS) : CNT_W'(`RTERM_WAIT_C2C);
         end else begin
            cnt_r <= CNT_W'(`RTERM_SETTLE);   // next sar step
         end
      end else if (cnt_r != '0) begin
         cnt_r <= cnt_r - 1'b1;
      end
   end

   // ----------------------------------------------------------
   // result registers and done flag
   // ----------------------------------------------------------
   always_ff @(posedge clk_ref_i or negedge reset_n_i) begin
      if (!reset_n_i) begin
         cal_c2c_r  <= 4'b1000;   // mid scale
         cal_lvds_r <= 4'b1000;
      end else if (sar_done) begin
         if (lvds_r) begin
            cal_lvds_r <= {val_r[3:1], cmp_keep};
         end else begin
            cal_c2c_r <= {val_r[3:1], cmp_keep};
         end
      end
   end

   always_ff @(posedge clk_ref_i or negedge reset_n_i) begin
      if (!reset_n_i) begin
         done_r <= 1'b0;
      end else if (state_nxt == CAL_IDLE) begin
         done_r <= 1'b0;
      end else if (sar_done && lvds_r) begin
         done_r <= 1'b1;                // first full c2c + lvds pass
      end
   end

   // ----------------------------------------------------------
   // outputs, trial code while searching, else stored code
   // ----------------------------------------------------------
   assign searching = (state_r != CAL_IDLE);

   assign rtermcal_mode_o   = searching ? {lvds_r, ~lvds_r} : 2'b00;
   assign rtermcal_d_iosg_o = therm_encode((searching && !lvds_r) ? val_r : cal_c2c_r);
   assign rtermcal_d_lvds_o = (searching && lvds_r) ? val_r : cal_lvds_r;

   assign calib_done_o = done_r;
   assign cal_c2c_o    = cal_c2c_r;
   assign cal_lvds_o   = cal_lvds_r;

endmodule

`default_nettype wire

// ==== source/rterm_apb_regs.sv ====
// termination calibration registers
`default_nettype none
`include "rterm_defs.svh"

module rterm_apb_regs (
   input  logic                                       clk_ref_i,
   input  logic                                       reset_n_i,
   // apb slave
   input  logic                                       psel_i,
   input  logic                                       penable_i,
   input  logic                                       pwrite_i,
   input  logic [`RTERM_APB_AW-1:0]                   paddr_i,
   input  logic [31:0]                                pwdata_i,
   output logic [31:0]                                prdata_o,
   output logic                                       pready_o,
   output logic                                       pslverr_o,
   // engines
   output logic [`RTERM_NUM_BANKS-1:0]                calib_en_o,
   input  logic [`RTERM_NUM_BANKS-1:0]                calib_done_i,
   // overrides towards code distribution
   output logic [`RTERM_NUM_BANKS-1:0]                c2c_ovr_o,
   output rterm_pkg::trim_code_t [`RTERM_NUM_BANKS-1:0] c2c_val_o,
   output logic [`RTERM_NUM_BANKS-1:0]                lvds_ovr_o,
   output rterm_pkg::trim_code_t [`RTERM_NUM_BANKS-1:0] lvds_val_o,
   // read-back from code distribution
   input  rterm_pkg::trim_code_t [`RTERM_NUM_BANKS-1:0] rb_c2c_i,
   input  rterm_pkg::trim_code_t [`RTERM_NUM_BANKS-1:0] rb_lvds_i
);
   import rterm_pkg::*;

   localparam int NB = `RTERM_NUM_BANKS;

   logic                wr_en;        // access phase write
   logic                rd_en;
   logic [NB-1:0]       ctrl_r;       // per bank enable
   logic [NB-1:0]       c2c_ovr_r;
   logic [NB-1:0]       lvds_ovr_r;
   trim_code_t [NB-1:0] c2c_val_r;
   trim_code_t [NB-1:0] lvds_val_r;

   // ----------------------------------------------------------
   // address decode helpers
   // ----------------------------------------------------------
   function automatic logic [`RTERM_APB_AW-1:0] ovr_addr(input int bank);
      return `RTERM_APB_AW'(`RTERM_ADDR_BANK_BASE + bank * `RTERM_BANK_STRIDE);
   endfunction

   function automatic logic [`RTERM_APB_AW-1:0] res_addr(input int bank);
      return ovr_addr(bank) + `RTERM_APB_AW'(`RTERM_OFS_RESULT);
   endfunction

   assign wr_en = psel_i & penable_i & pwrite_i;  // no wait states
   assign rd_en = psel_i & ~pwrite_i;

   // ----------------------------------------------------------
   // writable registers
   // ----------------------------------------------------------
   always_ff @(posedge clk_ref_i or negedge reset_n_i) begin
      if (!reset_n_i) begin
         ctrl_r     <= '0;
         c2c_ovr_r  <= '0;
         c2c_val_r  <= '0;
         lvds_ovr_r <= '0;
         lvds_val_r <= '0;
      end else if (wr_en) begin
         if (paddr_i == `RTERM_ADDR_CTRL) begin
            ctrl_r <= pwdata_i[NB-1:0];
         end
         for (int b = 0; b < NB; b++) begin
            if (paddr_i == ovr_addr(b)) begin
               c2c_ovr_r[b]  <= pwdata_i[0];
               c2c_val_r[b]  <= pwdata_i[4:1];
               lvds_ovr_r[b] <= pwdata_i[5];
               lvds_val_r[b] <= pwdata_i[9:6];
            end
         end
         // status, result and unmapped writes dropped
      end
   end

   // ----------------------------------------------------------
   // read mux, valid in setup and access phase
   // ----------------------------------------------------------
   always_comb begin
      prdata_o = '0;                         // unmapped reads 0
      if (rd_en) begin
         if (paddr_i == `RTERM_ADDR_CTRL) begin
            prdata_o[NB-1:0] = ctrl_r;
         end
         if (paddr_i == `RTERM_ADDR_STATUS) begin
            prdata_o[NB-1:0] = calib_done_i;  // done flags
         end
         for (int b = 0; b < NB; b++) begin
            if (paddr_i == ovr_addr(b)) begin
               prdata_o[9:0] = {lvds_val_r[b], lvds_ovr_r[b], c2c_val_r[b], c2c_ovr_r[b]};
            end
            if (paddr_i == res_addr(b)) begin
               prdata_o[7:0] = {rb_lvds_i[b], rb_c2c_i[b]};
            end
         end
      end
   end

   assign calib_en_o = ctrl_r;
   assign c2c_ovr_o  = c2c_ovr_r;
   assign c2c_val_o  = c2c_val_r;
   assign lvds_ovr_o = lvds_ovr_r;
   assign lvds_val_o = lvds_val_r;

   assign pready_o  = 1'b1;   // always ready
   assign pslverr_o = 1'b0;   // never errors

endmodule

`default_nettype wire

// ==== source/rterm_pkg.sv ====
// termination calibration types
`default_nettype none

package rterm_pkg;

   // 4 bit binary trim, 8 is mid scale
   typedef logic [3:0] trim_code_t;

   // thermometer trim for c2c cells, bit n set for code >= n
   typedef logic [15:1] therm_code_t;

   // sar engine states
   typedef enum logic [1:0] {
      CAL_IDLE = 2'd0,
      CAL_WAIT = 2'd1,   // let termination settle before search
      CAL_SAR  = 2'd2    // one bit per settle period
   } cal_state_t;

   // binary to thermometer, code n sets the low n bits
   function automatic therm_code_t therm_encode(input trim_code_t code);
      therm_code_t therm;
      for (int i = 1; i <= 15; i++) begin
         therm[i] = (code >= i);
      end
      return therm;
   endfunction

endpackage

`default_nettype wire

// ==== source/rterm_defs.svh ====
// termination calibration defines
`ifndef RTERM_DEFS_SVH
`define RTERM_DEFS_SVH

// ----------------------------------------------------------
// bank count
// ----------------------------------------------------------
`define RTERM_NUM_BANKS 2

// ----------------------------------------------------------
// engine timing, in clk_ref_i cycles
// ----------------------------------------------------------
`define RTERM_WAIT_C2C  30   // before each c2c search
`define RTERM_WAIT_LVDS 31   // before each lvds search
`define RTERM_SETTLE    50   // comparator settling per sar step

// ----------------------------------------------------------
// apb register map
// ----------------------------------------------------------
`define RTERM_APB_AW          12
`define RTERM_ADDR_CTRL       12'h000
`define RTERM_ADDR_STATUS     12'h004
`define RTERM_ADDR_BANK_BASE  12'h008   // override reg of bank 0
`define RTERM_BANK_STRIDE     8         // bytes per bank
`define RTERM_OFS_RESULT      4         // result reg, relative to bank base

`endif
